// File: rtl/axi_wr_mon_pkg.sv
`default_nettype none

package axi_wr_mon_pkg;

    // bus geometry of the monitored port
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;       // one strobe per byte lane
    localparam int LANE_BITS  = $clog2(STRB_WIDTH);   // byte lane index, 3 for 64b

    // AW field widths
    localparam int ID_WIDTH    = 2;   // 4 write ids
    localparam int LEN_WIDTH   = 8;   // beats - 1
    localparam int SIZE_WIDTH  = 3;   // log2 bytes per beat
    localparam int BURST_WIDTH = 2;

    // address queue between AW and W
    localparam int QUEUE_DEPTH_BITS = 3;   // 8 entries
    localparam int QUEUE_DEPTH      = 2 ** QUEUE_DEPTH_BITS;

    // a burst may not leave its 4 KB page
    localparam int PAGE_BITS = 12;

    // AxBURST encodings, 2'b11 is reserved
    localparam logic [BURST_WIDTH-1:0] BURST_FIXED = 2'd0;
    localparam logic [BURST_WIDTH-1:0] BURST_INCR  = 2'd1;
    localparam logic [BURST_WIDTH-1:0] BURST_WRAP  = 2'd2;

    // write address seen as one word or as page number over page offset
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [ADDR_WIDTH-PAGE_BITS-1:0] page;    // 4 KB page number
            logic [PAGE_BITS-1:0]            offset;  // byte offset inside the page
        } pg;
    } axi_addr_u;

endpackage

`default_nettype wire

// File: rtl/aw_queue.sv
`timescale 1ns/10ps
`default_nettype none

module aw_queue import axi_wr_mon_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   aw_hsk_i,
    input  wire logic                   w_hsk_i,
    input  wire logic                   w_last_i,
    input  wire logic [ADDR_WIDTH-1:0]  aw_addr_i,
    input  wire logic [LEN_WIDTH-1:0]   aw_len_i,
    input  wire logic [SIZE_WIDTH-1:0]  aw_size_i,
    input  wire logic [BURST_WIDTH-1:0] aw_burst_i,
    input  wire logic [ID_WIDTH-1:0]    aw_id_i,
    output logic      [ADDR_WIDTH-1:0]  cur_addr_o,
    output logic      [LEN_WIDTH-1:0]   cur_len_o,
    output logic      [SIZE_WIDTH-1:0]  cur_size_o,
    output logic      [BURST_WIDTH-1:0] cur_burst_o,
    output logic      [ID_WIDTH-1:0]    cur_id_o,
    output logic                        burst_valid_o,
    output logic                        err_overflow_o
);

    // storage, one array per AW field
    logic [ADDR_WIDTH-1:0]  addr_mem  [QUEUE_DEPTH];
    logic [LEN_WIDTH-1:0]   len_mem   [QUEUE_DEPTH];
    logic [SIZE_WIDTH-1:0]  size_mem  [QUEUE_DEPTH];
    logic [BURST_WIDTH-1:0] burst_mem [QUEUE_DEPTH];
    logic [ID_WIDTH-1:0]    id_mem    [QUEUE_DEPTH];

    logic [QUEUE_DEPTH_BITS:0] wr_ptr_q, rd_ptr_q;  // extra msb tells full from empty
    logic                      empty, full;
    logic                      bypass, push, pop;

    // held copy of a bypassed AW, served until its WLAST
    logic                   byp_q;
    logic [ADDR_WIDTH-1:0]  byp_addr_q;
    logic [LEN_WIDTH-1:0]   byp_len_q;
    logic [SIZE_WIDTH-1:0]  byp_size_q;
    logic [BURST_WIDTH-1:0] byp_burst_q;
    logic [ID_WIDTH-1:0]    byp_id_q;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[QUEUE_DEPTH_BITS] != rd_ptr_q[QUEUE_DEPTH_BITS]) &&
                   (wr_ptr_q[QUEUE_DEPTH_BITS-1:0] == rd_ptr_q[QUEUE_DEPTH_BITS-1:0]);

    // AW and first W beat together with nothing pending, skip the queue
    assign bypass = empty && !byp_q && aw_hsk_i && w_hsk_i;
    assign push   = aw_hsk_i && !bypass && !full;          // dropped when full
    assign pop    = w_hsk_i && w_last_i && !empty && !byp_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q[QUEUE_DEPTH_BITS-1:0]]  <= aw_addr_i;
            len_mem[wr_ptr_q[QUEUE_DEPTH_BITS-1:0]]   <= aw_len_i;
            size_mem[wr_ptr_q[QUEUE_DEPTH_BITS-1:0]]  <= aw_size_i;
            burst_mem[wr_ptr_q[QUEUE_DEPTH_BITS-1:0]] <= aw_burst_i;
            id_mem[wr_ptr_q[QUEUE_DEPTH_BITS-1:0]]    <= aw_id_i;
        end
    end

    // bypass burst stays current until its last beat
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            byp_q <= 1'b0;
        end else if (bypass && !w_last_i) begin
            byp_q <= 1'b1;                          // multi beat, keep serving the copy
        end else if (byp_q && w_hsk_i && w_last_i) begin
            byp_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bypass) begin
            byp_addr_q  <= aw_addr_i;
            byp_len_q   <= aw_len_i;
            byp_size_q  <= aw_size_i;
            byp_burst_q <= aw_burst_i;
            byp_id_q    <= aw_id_i;
        end
    end

    // read mux: live AW, held bypass copy, else queue head
    always_comb begin
        if (bypass) begin
            cur_addr_o  = aw_addr_i;
            cur_len_o   = aw_len_i;
            cur_size_o  = aw_size_i;
            cur_burst_o = aw_burst_i;
            cur_id_o    = aw_id_i;
        end else if (byp_q) begin
            cur_addr_o  = byp_addr_q;
            cur_len_o   = byp_len_q;
            cur_size_o  = byp_size_q;
            cur_burst_o = byp_burst_q;
            cur_id_o    = byp_id_q;
        end else begin
            cur_addr_o  = addr_mem[rd_ptr_q[QUEUE_DEPTH_BITS-1:0]];
            cur_len_o   = len_mem[rd_ptr_q[QUEUE_DEPTH_BITS-1:0]];
            cur_size_o  = size_mem[rd_ptr_q[QUEUE_DEPTH_BITS-1:0]];
            cur_burst_o = burst_mem[rd_ptr_q[QUEUE_DEPTH_BITS-1:0]];
            cur_id_o    = id_mem[rd_ptr_q[QUEUE_DEPTH_BITS-1:0]];
        end
    end

    assign burst_valid_o = bypass || byp_q || !empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_overflow_o <= 1'b0;
        end else if (aw_hsk_i && full) begin
            err_overflow_o <= 1'b1;                 // sticky until reset
        end
    end

endmodule

`default_nettype wire

// File: rtl/aw_rule_checker.sv
`timescale 1ns/10ps
`default_nettype none

module aw_rule_checker import axi_wr_mon_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   aw_hsk_i,
    input  wire logic [ADDR_WIDTH-1:0]  aw_addr_i,
    input  wire logic [LEN_WIDTH-1:0]   aw_len_i,
    input  wire logic [SIZE_WIDTH-1:0]  aw_size_i,
    input  wire logic [BURST_WIDTH-1:0] aw_burst_i,
    output logic                        err_aw_rule_o,
    output logic                        err_boundary_o
);

    axi_addr_u addr_u;

    logic                        is_wrap;
    logic                        reserved_burst, size_too_big;
    logic                        wrap_len_bad, wrap_unaligned;
    logic                        rule_bad;
    logic [ADDR_WIDTH-1:0]       align_mask;     // low address bits below the beat size
    logic [PAGE_BITS+LEN_WIDTH:0] burst_bytes;   // beats * 2^size, up to 256 * 128
    logic [PAGE_BITS+LEN_WIDTH:0] end_offset;    // first byte past the burst, page relative
    logic                        crosses_page;

    assign addr_u.flat = aw_addr_i;

    assign is_wrap        = (aw_burst_i == BURST_WRAP);
    assign reserved_burst = (aw_burst_i == 2'd3);
    assign size_too_big   = (aw_size_i > SIZE_WIDTH'(LANE_BITS));  // wider than the bus

    // wrap bursts only come in 2, 4, 8 or 16 beats
    assign wrap_len_bad = is_wrap && !((aw_len_i == 8'd1) || (aw_len_i == 8'd3) ||
                                       (aw_len_i == 8'd7) || (aw_len_i == 8'd15));

    assign align_mask     = (ADDR_WIDTH'(1) << aw_size_i) - ADDR_WIDTH'(1);
    assign wrap_unaligned = is_wrap && ((addr_u.flat & align_mask) != '0);

    assign rule_bad = reserved_burst || size_too_big || wrap_len_bad || wrap_unaligned;

    // page check uses the offset view of the address
    assign burst_bytes  = ({{PAGE_BITS{1'b0}}, aw_len_i} + 1'b1) << aw_size_i;
    assign end_offset   = {{LEN_WIDTH{1'b0}}, 1'b0, addr_u.pg.offset} + burst_bytes;
    assign crosses_page = (aw_burst_i == BURST_INCR) &&
                          (end_offset > ((PAGE_BITS+LEN_WIDTH+1)'(1) << PAGE_BITS));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_aw_rule_o  <= 1'b0;
            err_boundary_o <= 1'b0;
        end else if (aw_hsk_i) begin
            if (rule_bad)     err_aw_rule_o  <= 1'b1;   // sticky
            if (crosses_page) err_boundary_o <= 1'b1;   // sticky
        end
    end

endmodule

`default_nettype wire

// File: rtl/w_beat_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module w_beat_tracker import axi_wr_mon_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   w_hsk_i,
    input  wire logic                   w_last_i,
    input  wire logic [STRB_WIDTH-1:0]  w_strb_i,
    input  wire logic                   burst_valid_i,
    input  wire logic [ADDR_WIDTH-1:0]  cur_addr_i,
    input  wire logic [LEN_WIDTH-1:0]   cur_len_i,
    input  wire logic [SIZE_WIDTH-1:0]  cur_size_i,
    input  wire logic [BURST_WIDTH-1:0] cur_burst_i,
    output logic                        beat_first_o,
    output logic                        err_wlast_o,
    output logic                        err_strb_o,
    output logic                        err_worder_o
);

    logic [LEN_WIDTH:0]  beat_q;         // beats taken so far in the current burst
    logic [LANE_BITS-1:0] lane_q;        // start lane of the next beat
    logic                beat_hsk;       // W beat that belongs to a known burst
    logic                last_expected;

    logic [LANE_BITS-1:0]  lane;         // start lane of this beat
    logic [LANE_BITS-1:0]  size_mask;
    logic [LANE_BITS-1:0]  lane_base;    // size aligned container start
    logic [STRB_WIDTH-1:0] lane_fill;    // 2^size ones at lane 0
    logic [STRB_WIDTH-1:0] cont_strb;    // the whole container at this beat
    logic [STRB_WIDTH-1:0] exp_strb;
    logic                  strb_checked;

    assign beat_hsk      = w_hsk_i && burst_valid_i;
    assign beat_first_o  = (beat_q == '0);
    assign last_expected = (beat_q == {1'b0, cur_len_i});   // WLAST exactly on beat len

    // beat counter, restarts on every WLAST so it stays in step with the queue pop
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
        end else if (beat_hsk) begin
            if (w_last_i) beat_q <= '0;
            else          beat_q <= beat_q + 1'b1;
        end
    end

    // first beat starts at the low address bits, later beats at the pointer
    assign lane      = beat_first_o ? cur_addr_i[LANE_BITS-1:0] : lane_q;
    assign size_mask = LANE_BITS'((32'd1 << cur_size_i) - 32'd1);
    assign lane_base = lane & ~size_mask;

    assign lane_fill = {STRB_WIDTH{1'b1}} >> (STRB_WIDTH - (32'd1 << cur_size_i));
    assign cont_strb = lane_fill << lane_base;

    // unaligned first beat only covers lane..container end
    assign exp_strb = beat_first_o ? (cont_strb & ({STRB_WIDTH{1'b1}} << lane)) : cont_strb;

    // lanes wider than the bus and wrap bursts are not strobe checked
    assign strb_checked = (cur_size_i <= SIZE_WIDTH'(LANE_BITS)) &&
                          ((cur_burst_i == BURST_INCR) || (cur_burst_i == BURST_FIXED));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lane_q <= '0;
        end else if (beat_hsk) begin
            if (cur_burst_i == BURST_INCR) begin
                lane_q <= lane_base + LANE_BITS'(32'd1 << cur_size_i);  // wraps on the bus
            end else begin
                lane_q <= lane;                     // fixed keeps its lane
            end
        end
    end

    // sticky error flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_wlast_o  <= 1'b0;
            err_strb_o   <= 1'b0;
            err_worder_o <= 1'b0;
        end else begin
            if (beat_hsk && (w_last_i != last_expected)) begin
                err_wlast_o <= 1'b1;                // early or missing WLAST
            end
            if (beat_hsk && strb_checked && (w_strb_i != exp_strb)) begin
                err_strb_o <= 1'b1;
            end
            if (w_hsk_i && !burst_valid_i) begin
                err_worder_o <= 1'b1;               // data ahead of its address
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/wr_id_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module wr_id_tracker import axi_wr_mon_pkg::*; (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire logic                aw_hsk_i,
    input  wire logic [ID_WIDTH-1:0] aw_id_i,
    input  wire logic                w_done_i,
    input  wire logic [ID_WIDTH-1:0] cur_id_i,
    input  wire logic                b_hsk_i,
    input  wire logic [ID_WIDTH-1:0] b_id_i,
    output logic                     err_id_o
);

    // per id state
    logic [2**ID_WIDTH-1:0] outstanding_q;   // address accepted, no B yet
    logic [2**ID_WIDTH-1:0] data_done_q;     // last W beat seen, B may come

    for (genvar i = 0; i < 2**ID_WIDTH; i++) begin : g_id
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                outstanding_q[i] <= 1'b0;
            end else if (aw_hsk_i && (aw_id_i == ID_WIDTH'(i))) begin
                outstanding_q[i] <= 1'b1;
            end else if (b_hsk_i && (b_id_i == ID_WIDTH'(i))) begin
                outstanding_q[i] <= 1'b0;           // released by its response
            end
        end

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                data_done_q[i] <= 1'b0;
            end else if (b_hsk_i && (b_id_i == ID_WIDTH'(i))) begin
                data_done_q[i] <= 1'b0;
            end else if (w_done_i && (cur_id_i == ID_WIDTH'(i))) begin
                data_done_q[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_id_o <= 1'b0;
        end else begin
            // awid reuse while the earlier write is still open
            if (aw_hsk_i && outstanding_q[aw_id_i]) err_id_o <= 1'b1;
            // response without a completed write for that id
            if (b_hsk_i && !data_done_q[b_id_i])    err_id_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/axi_wr_mon.sv
`timescale 1ns/10ps
`default_nettype none

module axi_wr_mon import axi_wr_mon_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    // AW channel
    input  wire logic                   aw_valid_i,
    input  wire logic                   aw_ready_i,
    input  wire logic [ADDR_WIDTH-1:0]  aw_addr_i,
    input  wire logic [LEN_WIDTH-1:0]   aw_len_i,
    input  wire logic [SIZE_WIDTH-1:0]  aw_size_i,
    input  wire logic [BURST_WIDTH-1:0] aw_burst_i,
    input  wire logic [ID_WIDTH-1:0]    aw_id_i,
    // W channel, data itself is not checked
    input  wire logic                   w_valid_i,
    input  wire logic                   w_ready_i,
    input  wire logic [STRB_WIDTH-1:0]  w_strb_i,
    input  wire logic                   w_last_i,
    // B channel
    input  wire logic                   b_valid_i,
    input  wire logic                   b_ready_i,
    input  wire logic [ID_WIDTH-1:0]    b_id_i,
    // sticky error flags
    output logic                        err_overflow_o,
    output logic                        err_aw_rule_o,
    output logic                        err_boundary_o,
    output logic                        err_wlast_o,
    output logic                        err_strb_o,
    output logic                        err_worder_o,
    output logic                        err_id_o
);

    logic aw_hsk, w_hsk, b_hsk, w_done;

    // burst that W is currently serving
    logic [ADDR_WIDTH-1:0]  cur_addr;
    logic [LEN_WIDTH-1:0]   cur_len;
    logic [SIZE_WIDTH-1:0]  cur_size;
    logic [BURST_WIDTH-1:0] cur_burst;
    logic [ID_WIDTH-1:0]    cur_id;
    logic                   burst_valid;

    assign aw_hsk = aw_valid_i && aw_ready_i;
    assign w_hsk  = w_valid_i && w_ready_i;
    assign b_hsk  = b_valid_i && b_ready_i;
    assign w_done = w_hsk && w_last_i;      // write data complete for cur_id

    aw_queue i_aw_queue (
        .clk_i, .rst_ni,
        .aw_hsk_i       (aw_hsk),
        .w_hsk_i        (w_hsk),
        .w_last_i,
        .aw_addr_i, .aw_len_i, .aw_size_i, .aw_burst_i, .aw_id_i,
        .cur_addr_o     (cur_addr),
        .cur_len_o      (cur_len),
        .cur_size_o     (cur_size),
        .cur_burst_o    (cur_burst),
        .cur_id_o       (cur_id),
        .burst_valid_o  (burst_valid),
        .err_overflow_o
    );

    aw_rule_checker i_aw_rule_checker (
        .clk_i, .rst_ni,
        .aw_hsk_i       (aw_hsk),
        .aw_addr_i, .aw_len_i, .aw_size_i, .aw_burst_i,
        .err_aw_rule_o, .err_boundary_o
    );

    w_beat_tracker i_w_beat_tracker (
        .clk_i, .rst_ni,
        .w_hsk_i        (w_hsk),
        .w_last_i, .w_strb_i,
        .burst_valid_i  (burst_valid),
        .cur_addr_i     (cur_addr),
        .cur_len_i      (cur_len),
        .cur_size_i     (cur_size),
        .cur_burst_i    (cur_burst),
        .beat_first_o   (),                 // first beat marker, only used inside
        .err_wlast_o, .err_strb_o, .err_worder_o
    );

    wr_id_tracker i_wr_id_tracker (
        .clk_i, .rst_ni,
        .aw_hsk_i       (aw_hsk),
        .aw_id_i,
        .w_done_i       (w_done),
        .cur_id_i       (cur_id),
        .b_hsk_i        (b_hsk),
        .b_id_i,
        .err_id_o
    );

endmodule

`default_nettype wire

// File: tb/axi_wr_mon_tb.sv
`timescale 1ns/10ps
`default_nettype none

module axi_wr_mon_tb import axi_wr_mon_pkg::*; ();

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic                   aw_valid_i, aw_ready_i;
    logic [ADDR_WIDTH-1:0]  aw_addr_i;
    logic [LEN_WIDTH-1:0]   aw_len_i;
    logic [SIZE_WIDTH-1:0]  aw_size_i;
    logic [BURST_WIDTH-1:0] aw_burst_i;
    logic [ID_WIDTH-1:0]    aw_id_i, b_id_i;
    logic                   w_valid_i, w_ready_i, w_last_i;
    logic [STRB_WIDTH-1:0]  w_strb_i;
    logic                   b_valid_i, b_ready_i;
    logic err_overflow_o, err_aw_rule_o, err_boundary_o, err_wlast_o;
    logic err_strb_o, err_worder_o, err_id_o;

    // expected flags, raised by the model on the edge that ends the bad handshake
    logic exp_overflow, exp_aw_rule, exp_boundary, exp_wlast, exp_strb, exp_worder, exp_id;
    logic [46:0] pending [$];       // open AWs as {id, burst, size, len, addr}
    logic [3:0]  id_open, id_done;  // per id: AW seen, WLAST seen

    axi_wr_mon i_dut (.*);

    always #10 clk_i = ~clk_i;

    // flags checked mid cycle where they are stable
    always @(negedge clk_i) begin
        assert (err_overflow_o == exp_overflow)
            else flag_mismatch("err_overflow_o", exp_overflow, err_overflow_o);
        assert (err_aw_rule_o == exp_aw_rule)
            else flag_mismatch("err_aw_rule_o", exp_aw_rule, err_aw_rule_o);
        assert (err_boundary_o == exp_boundary)
            else flag_mismatch("err_boundary_o", exp_boundary, err_boundary_o);
        assert (err_wlast_o == exp_wlast)
            else flag_mismatch("err_wlast_o", exp_wlast, err_wlast_o);
        assert (err_strb_o == exp_strb) else flag_mismatch("err_strb_o", exp_strb, err_strb_o);
        assert (err_worder_o == exp_worder)
            else flag_mismatch("err_worder_o", exp_worder, err_worder_o);
        assert (err_id_o == exp_id) else flag_mismatch("err_id_o", exp_id, err_id_o);
    end

    task automatic flag_mismatch(input string name, input logic exp_val, input logic act_val);
        $display("[FAIL] %0t ns %s expected %0b actual %0b", $time, name, exp_val, act_val);
        $display("=== FAIL ===");
        $fatal(1, "flag check failed");
    endtask

    task automatic timeout_fail(input string chan);
        $display("timeout: no %s handshake within 200 cycles", chan);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // byte lanes a beat may write
    function automatic logic [7:0] lane_strb(input logic [2:0] lane0, input logic [2:0] size,
                                             input logic [1:0] burst, input int beat);
        int         nb, base;
        logic [7:0] fill;
        nb   = 1 << size;
        base = int'(lane0) - int'(lane0) % nb;          // container of the start address
        fill = 8'((1 << nb) - 1);
        if (beat == 0) lane_strb = (fill << base) & (8'hff << lane0);  // partial first beat
        else if (burst == BURST_INCR) lane_strb = fill << ((base + beat * nb) % 8);
        else lane_strb = fill << base;                  // fixed stays on its lanes
    endfunction

    task automatic note_aw(input logic [31:0] addr, input logic [7:0] len,
                           input logic [2:0] size, input logic [1:0] burst, input logic [1:0] id);
        int bytes;
        bytes = (int'(len) + 1) << size;
        if (burst == 2'd3 || size > 3) exp_aw_rule = 1'b1;
        if (burst == BURST_WRAP && !(len inside {8'd1, 8'd3, 8'd7, 8'd15})) exp_aw_rule = 1'b1;
        if (burst == BURST_WRAP && (addr % (32'd1 << size)) != 0) exp_aw_rule = 1'b1;
        if (burst == BURST_INCR && int'(addr[11:0]) + bytes > 4096) exp_boundary = 1'b1;
        if (id_open[id]) exp_id = 1'b1;                 // id still waiting for B
        id_open[id] = 1'b1;
        if (pending.size() >= 8) exp_overflow = 1'b1;   // 9th entry is lost
        else pending.push_back({id, burst, size, len, addr});
    endtask

    task automatic note_w(input int beat, input logic last, input logic [7:0] strb);
        logic [46:0] cur;
        if (pending.size() == 0) begin
            exp_worder = 1'b1;                          // data ahead of any address
        end else begin
            cur = pending[0];
            if (cur[44:43] != BURST_WRAP &&
                strb != lane_strb(cur[2:0], cur[42:40], cur[44:43], beat))
                exp_strb = 1'b1;
            if (last != (beat == int'(cur[39:32]))) exp_wlast = 1'b1;
            if (last) begin
                id_done[cur[46:45]] = 1'b1;
                pending.delete(0);
            end
        end
    endtask

    task automatic send_aw(input logic [31:0] addr, input logic [7:0] len,
                           input logic [2:0] size, input logic [1:0] burst, input logic [1:0] id);
        int   n;
        logic done;
        aw_valid_i = 1'b1;
        aw_addr_i  = addr;
        aw_len_i   = len;
        aw_size_i  = size;
        aw_burst_i = burst;
        aw_id_i    = id;
        done       = 1'b0;
        for (n = 0; n < 200 && !done; n++) begin
            aw_ready_i = ($urandom % 4) != 0;           // random back pressure
            @(posedge clk_i);
            if (aw_ready_i) begin
                note_aw(addr, len, size, burst, id);
                done = 1'b1;
            end
            #2;
        end
        aw_valid_i = 1'b0;
        aw_ready_i = 1'b0;
        if (!done) timeout_fail("AW");
    endtask

    // beats first..last_at of the head burst, bad_beat gets inverted strobes
    task automatic send_w(input int first, input int last_at, input int bad_beat);
        int         n;
        logic       done;
        logic [7:0] strb;
        for (int beat = first; beat <= last_at; beat++) begin
            strb = 8'hff;
            if (pending.size() > 0)
                strb = lane_strb(pending[0][2:0], pending[0][42:40], pending[0][44:43], beat);
            if (beat == bad_beat) strb = ~strb;
            w_valid_i = 1'b1;
            w_strb_i  = strb;
            w_last_i  = (beat == last_at);
            done      = 1'b0;
            for (n = 0; n < 200 && !done; n++) begin
                w_ready_i = ($urandom % 4) != 0;
                @(posedge clk_i);
                if (w_ready_i) begin
                    note_w(beat, w_last_i, strb);
                    done = 1'b1;
                end
                #2;
            end
            if (!done) timeout_fail("W");
        end
        w_valid_i = 1'b0;
        w_ready_i = 1'b0;
        w_last_i  = 1'b0;
    endtask

    // AW and first W beat in one cycle, the queue bypass case
    task automatic send_aw_w(input logic [31:0] addr, input logic [7:0] len,
                             input logic [2:0] size, input logic [1:0] id);
        {aw_valid_i, aw_ready_i, w_valid_i, w_ready_i} = 4'hf;
        aw_addr_i  = addr;
        aw_len_i   = len;
        aw_size_i  = size;
        aw_burst_i = BURST_INCR;
        aw_id_i    = id;
        w_strb_i   = lane_strb(addr[2:0], size, BURST_INCR, 0);
        w_last_i   = (len == 0);
        @(posedge clk_i);
        note_aw(addr, len, size, BURST_INCR, id);
        note_w(0, w_last_i, w_strb_i);
        #2;
        {aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i} = 5'h0;
        if (len > 0) send_w(1, int'(len), -1);
    endtask

    task automatic send_b(input logic [1:0] id);
        int   n;
        logic done;
        b_valid_i = 1'b1;
        b_id_i    = id;
        done      = 1'b0;
        for (n = 0; n < 200 && !done; n++) begin
            b_ready_i = ($urandom % 4) != 0;
            @(posedge clk_i);
            if (b_ready_i) begin
                if (!id_done[id]) exp_id = 1'b1;        // response before the data
                id_open[id] = 1'b0;
                id_done[id] = 1'b0;
                done = 1'b1;
            end
            #2;
        end
        b_valid_i = 1'b0;
        b_ready_i = 1'b0;
        if (!done) timeout_fail("B");
    endtask

    task automatic apply_reset();
        rst_ni = 1'b0;
        {exp_overflow, exp_aw_rule, exp_boundary, exp_wlast} = 4'h0;
        {exp_strb, exp_worder, exp_id} = 3'h0;
        pending.delete();
        id_open = '0;
        id_done = '0;
        repeat (2) @(posedge clk_i);
        #2 rst_ni = 1'b1;
    endtask

    initial begin
        void'($urandom(97606));
        {aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i, b_valid_i, b_ready_i} = '0;
        aw_addr_i  = '0;
        aw_len_i   = '0;
        aw_size_i  = '0;
        aw_burst_i = '0;
        aw_id_i    = '0;
        b_id_i     = '0;
        w_strb_i   = '0;
        apply_reset();

        // legal INCR of every size, aligned then unaligned
        for (int s = 0; s < 4; s++) begin
            send_aw(32'h1000 + 32'(s * 64), 8'd3, 3'(s), BURST_INCR, 2'(s));
            send_w(0, 3, -1);
            send_b(2'(s));
            send_aw(32'h2003 + 32'(s * 64), 8'd2, 3'(s), BURST_INCR, 2'(s));
            send_w(0, 2, -1);
            send_b(2'(s));
        end
        send_aw(32'h3005, 8'd3, 3'd1, BURST_FIXED, 2'd1);
        send_w(0, 3, -1);
        send_b(2'd1);
        send_aw(32'h3040, 8'd3, 3'd3, BURST_WRAP, 2'd2);
        send_w(0, 3, 1);                    // beat 1 writes no lanes, wrap strobes go unchecked
        send_b(2'd2);
        // three ids queued ahead of their data, responses out of order
        send_aw(32'h5000, 8'd1, 3'd3, BURST_INCR, 2'd0);
        send_aw(32'h5101, 8'd2, 3'd0, BURST_INCR, 2'd1);
        send_aw(32'h5206, 8'd3, 3'd1, BURST_FIXED, 2'd2);
        send_w(0, 1, -1);
        send_w(0, 2, -1);
        send_w(0, 3, -1);
        send_b(2'd2);
        send_b(2'd0);
        send_b(2'd1);
        send_aw_w(32'h4000, 8'd0, 3'd3, 2'd3);
        send_b(2'd3);
        send_aw_w(32'h4102, 8'd3, 3'd1, 2'd0);
        send_b(2'd0);

        // WLAST early, WLAST missing, bad strobe on first and on a later beat
        apply_reset();
        send_aw(32'h100, 8'd3, 3'd3, BURST_INCR, 2'd0);
        send_w(0, 1, -1);
        apply_reset();
        send_aw(32'h100, 8'd1, 3'd3, BURST_INCR, 2'd0);
        send_w(0, 2, -1);
        apply_reset();
        send_aw(32'h103, 8'd1, 3'd2, BURST_INCR, 2'd0);
        send_w(0, 1, 0);
        apply_reset();
        send_aw(32'h100, 8'd3, 3'd2, BURST_INCR, 2'd0);
        send_w(0, 3, 2);

        // AW rule violations, one per reset
        apply_reset();
        send_aw(32'h100, 8'd0, 3'd0, 2'd3, 2'd0);
        apply_reset();
        send_aw(32'h100, 8'd0, 3'd4, BURST_INCR, 2'd0);
        apply_reset();
        send_aw(32'h200, 8'd2, 3'd3, BURST_WRAP, 2'd0);
        apply_reset();
        send_aw(32'h1002, 8'd3, 3'd2, BURST_WRAP, 2'd0);
        apply_reset();
        send_aw(32'hff8, 8'd1, 3'd3, BURST_INCR, 2'd0);

        // W with no AW, then nine AWs and no data
        apply_reset();
        send_w(0, 0, -1);
        apply_reset();
        for (int i = 0; i < 9; i++) send_aw(32'(i * 256), 8'd0, 3'd0, BURST_INCR, 2'(i));

        // id reuse, then B without data, reset clears the flag
        apply_reset();
        send_aw(32'h100, 8'd0, 3'd0, BURST_INCR, 2'd1);
        send_aw(32'h200, 8'd0, 3'd0, BURST_INCR, 2'd1);
        apply_reset();
        send_aw(32'h100, 8'd0, 3'd0, BURST_INCR, 2'd2);
        send_b(2'd2);
        apply_reset();
        repeat (3) @(posedge clk_i);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: axi_wr_mon.f
rtl/axi_wr_mon_pkg.sv
rtl/aw_queue.sv
rtl/aw_rule_checker.sv
rtl/w_beat_tracker.sv
rtl/wr_id_tracker.sv
rtl/axi_wr_mon.sv
tb/axi_wr_mon_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the monitor and its testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_wr_mon_tb -f axi_wr_mon.f -o sim_axi_wr_mon

./obj_dir/sim_axi_wr_mon 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
